// ==== sya_pkg.sv ====
// Shared types for the systolic matrix engine
// Data widths, configuration word layout and sequencer states

`default_nettype none

package sya_pkg;

    // ==============================
    // Widths
    // ==============================
    localparam int ACT_W   = 8;
    localparam int WGT_W   = 8;
    localparam int CHN_W   = 16;
    localparam int PSUM_W  = ACT_W + WGT_W + CHN_W;
    localparam int ADDR_W  = 16;
    localparam int SHIFT_W = 5;

    // Data and index types
    typedef logic signed [ACT_W-1:0]  act_t;
    typedef logic signed [WGT_W-1:0]  wgt_t;
    typedef logic signed [PSUM_W-1:0] psum_t;
    typedef logic [ADDR_W-1:0]        addr_t;
    typedef logic [CHN_W-1:0]         chn_t;
    typedef logic [SHIFT_W-1:0]       shift_t;

    // ==============================
    // Configuration word, 77 bits
    // ==============================
    typedef struct packed {
        addr_t  ofm_base;
        addr_t  act_base;
        addr_t  wgt_base;
        chn_t   num_chn;    // At least one channel
        shift_t shift;
        act_t   zp;
    } sya_cfg_t;

    // Sequencer states
    typedef enum logic [1:0] {
        IDLE  = 2'd0,
        LOAD  = 2'd1,
        DRAIN = 2'd2,
        WRITE = 2'd3
    } seq_state_t;

endpackage

`default_nettype wire

// ==== sya_pe.sv ====
// Multiply-accumulate processing element
// Activation moves east, weight moves south, the sum stays in place

`timescale 1ns/100ps
`default_nettype none

module sya_pe (
    input  wire             clk,
    input  wire             rst_n,
    input  wire             step,
    input  wire             clear_acc,
    input  sya_pkg::act_t   act_in,
    input  sya_pkg::wgt_t   wgt_in,
    output sya_pkg::act_t   act_out,
    output sya_pkg::wgt_t   wgt_out,
    output sya_pkg::psum_t  psum
);
    import sya_pkg::*;

    psum_t prod;

    // Sign extended product
    assign prod = psum_t'(act_in) * psum_t'(wgt_in);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            act_out <= '0;
            wgt_out <= '0;
            psum    <= '0;
        end else begin
            if (clear_acc) begin
                psum <= '0;
            end else if (step) begin
                psum <= psum + prod;
            end
            // Operands hop to the neighbors on every step
            if (step) begin
                act_out <= act_in;
                wgt_out <= wgt_in;
            end
        end
    end

endmodule

`default_nettype wire

// ==== sya_array.sv ====
// Output-stationary PE grid with input skew
// Row r activations lag r steps, column c weights lag c steps

`timescale 1ns/100ps
`default_nettype none

module sya_array #(
    parameter int NUM_ROW = 4,
    parameter int NUM_COL = 4
) (
    input  wire                                               clk,
    input  wire                                               rst_n,
    input  wire                                               step,
    input  wire                                               feed_zero,
    input  wire                                               clear_acc,
    input  sya_pkg::act_t [NUM_ROW-1:0]                       act_vec,
    input  sya_pkg::wgt_t [NUM_COL-1:0]                       wgt_vec,
    output wire sya_pkg::psum_t [NUM_ROW-1:0][NUM_COL-1:0]    psum
);
    import sya_pkg::*;

    act_t [NUM_ROW-1:0]                 act_entry;
    wgt_t [NUM_COL-1:0]                 wgt_entry;
    // Horizontal and vertical links, one extra slot past the edge
    wire act_t [NUM_ROW-1:0][NUM_COL:0] act_h;
    wire wgt_t [NUM_ROW:0][NUM_COL-1:0] wgt_v;

    // Zeros flush the grid during drain
    assign act_entry = feed_zero ? '0 : act_vec;
    assign wgt_entry = feed_zero ? '0 : wgt_vec;

    // ==============================
    // Input skew
    // ==============================
    for (genvar r = 0; r < NUM_ROW; r++) begin : g_act_skew
        if (r == 0) begin : g_direct
            assign act_h[r][0] = act_entry[r];
        end else begin : g_dly
            act_t dly [r];
            always_ff @(posedge clk or negedge rst_n) begin
                if (!rst_n) begin
                    for (int i = 0; i < r; i++) begin
                        dly[i] <= '0;
                    end
                end else if (step) begin
                    dly[0] <= act_entry[r];
                    for (int i = 1; i < r; i++) begin
                        dly[i] <= dly[i-1];
                    end
                end
            end
            assign act_h[r][0] = dly[r-1];
        end
    end

    for (genvar c = 0; c < NUM_COL; c++) begin : g_wgt_skew
        if (c == 0) begin : g_direct
            assign wgt_v[0][c] = wgt_entry[c];
        end else begin : g_dly
            wgt_t dly [c];
            always_ff @(posedge clk or negedge rst_n) begin
                if (!rst_n) begin
                    for (int i = 0; i < c; i++) begin
                        dly[i] <= '0;
                    end
                end else if (step) begin
                    dly[0] <= wgt_entry[c];
                    for (int i = 1; i < c; i++) begin
                        dly[i] <= dly[i-1];
                    end
                end
            end
            assign wgt_v[0][c] = dly[c-1];
        end
    end

    // ==============================
    // PE grid
    // ==============================
    for (genvar r = 0; r < NUM_ROW; r++) begin : g_row
        for (genvar c = 0; c < NUM_COL; c++) begin : g_col
            sya_pe u_pe (
                .clk       (clk),
                .rst_n     (rst_n),
                .step      (step),
                .clear_acc (clear_acc),
                .act_in    (act_h[r][c]),
                .wgt_in    (wgt_v[r][c]),
                .act_out   (act_h[r][c+1]),
                .wgt_out   (wgt_v[r+1][c]),
                .psum      (psum[r][c])
            );
        end
    end

endmodule

`default_nettype wire

// ==== sya_seq.sv ====
// Job sequencer for the systolic matrix engine
// Takes the configuration, issues channel reads, steps and drains the grid

`timescale 1ns/100ps
`default_nettype none

module sya_seq #(
    parameter int NUM_ROW = 4,
    parameter int NUM_COL = 4
) (
    input  wire                 clk,
    input  wire                 rst_n,
    input  wire                 cfg_vld,
    input  sya_pkg::sya_cfg_t   cfg,
    input  wire                 act_rd_addr_rdy,
    input  wire                 wgt_rd_addr_rdy,
    input  wire                 act_rd_dat_vld,
    input  wire                 wgt_rd_dat_vld,
    input  wire                 write_done,
    output logic                cfg_rdy,
    output sya_pkg::sya_cfg_t   cfg_q,
    output sya_pkg::addr_t      act_rd_addr,
    output sya_pkg::addr_t      wgt_rd_addr,
    output logic                act_rd_addr_vld,
    output logic                wgt_rd_addr_vld,
    output logic                act_rd_dat_rdy,
    output logic                wgt_rd_dat_rdy,
    output logic                step,
    output logic                feed_zero,
    output logic                clear_acc,
    output logic                drain_done
);
    import sya_pkg::*;

    // Steps needed to push the last beat into the far corner PE
    localparam int DRAIN_LEN = NUM_ROW + NUM_COL - 2;
    localparam int DRN_W     = $clog2(DRAIN_LEN + 2);

    seq_state_t       state;
    seq_state_t       state_nxt;
    chn_t             req_cnt;
    chn_t             beat_cnt;
    chn_t             last_idx;
    logic [DRN_W-1:0] drain_cnt;
    logic             cfg_acc;
    logic             req_pend;
    logic             req_fire;
    logic             beat_pend;
    logic             beat_fire;
    logic             last_beat;
    logic             drain_last;

    assign cfg_rdy   = (state == IDLE);
    assign cfg_acc   = cfg_vld & cfg_rdy;
    assign clear_acc = cfg_acc;
    assign last_idx  = cfg_q.num_chn - 1'b1;

    // ==============================
    // Read requests
    // ==============================
    // Each valid waits on the other channel's ready
    assign req_pend        = (state == LOAD) && (req_cnt != cfg_q.num_chn);
    assign act_rd_addr_vld = req_pend & wgt_rd_addr_rdy;
    assign wgt_rd_addr_vld = req_pend & act_rd_addr_rdy;
    assign req_fire        = req_pend & act_rd_addr_rdy & wgt_rd_addr_rdy;
    assign act_rd_addr     = cfg_q.act_base + req_cnt;
    assign wgt_rd_addr     = cfg_q.wgt_base + req_cnt;

    // Read data beats, one grid step each
    assign beat_pend      = (state == LOAD) && (beat_cnt != cfg_q.num_chn);
    assign act_rd_dat_rdy = beat_pend;
    assign wgt_rd_dat_rdy = beat_pend;
    assign beat_fire      = beat_pend & act_rd_dat_vld & wgt_rd_dat_vld;
    assign last_beat      = beat_fire && (beat_cnt == last_idx);

    assign drain_last = (drain_cnt == DRN_W'(DRAIN_LEN - 1));
    assign step       = beat_fire | (state == DRAIN);
    assign feed_zero  = (state == DRAIN);

    // ==============================
    // State machine
    // ==============================
    always_comb begin
        state_nxt = state;
        case (state)
            IDLE:    if (cfg_acc) state_nxt = LOAD;
            LOAD:    if (last_beat) state_nxt = (DRAIN_LEN == 0) ? WRITE : DRAIN;
            DRAIN:   if (drain_last) state_nxt = WRITE;
            WRITE:   if (write_done) state_nxt = IDLE;
            default: state_nxt = IDLE;
        endcase
    end

    // Done pulse lands once the last step has settled in the grid
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state      <= IDLE;
            drain_done <= 1'b0;
            drain_cnt  <= '0;
        end else begin
            state      <= state_nxt;
            drain_done <= (state_nxt == WRITE) && (state != WRITE);
            if (state == DRAIN) begin
                drain_cnt <= drain_cnt + 1'b1;
            end else begin
                drain_cnt <= '0;
            end
        end
    end

    // Configuration and channel counters
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            cfg_q    <= '0;
            req_cnt  <= '0;
            beat_cnt <= '0;
        end else if (cfg_acc) begin
            cfg_q    <= cfg;
            req_cnt  <= '0;
            beat_cnt <= '0;
        end else begin
            if (req_fire) begin
                req_cnt <= req_cnt + 1'b1;
            end
            if (beat_fire) begin
                beat_cnt <= beat_cnt + 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

// ==== sya_ofm_writer.sv ====
// Output row writer with requantization
// ReLU, right shift and zero point per element, one row per write

`timescale 1ns/100ps
`default_nettype none

module sya_ofm_writer #(
    parameter int NUM_ROW = 4,
    parameter int NUM_COL = 4
) (
    input  wire                                         clk,
    input  wire                                         rst_n,
    input  wire                                         drain_done,
    input  sya_pkg::sya_cfg_t                           cfg_q,
    input  sya_pkg::psum_t [NUM_ROW-1:0][NUM_COL-1:0]   psum,
    input  wire                                         ofm_wr_rdy,
    output logic                                        ofm_wr_vld,
    output sya_pkg::addr_t                              ofm_wr_addr,
    output sya_pkg::act_t [NUM_COL-1:0]                 ofm_wr_dat,
    output logic                                        write_done
);
    import sya_pkg::*;

    localparam int ROW_W = (NUM_ROW > 1) ? $clog2(NUM_ROW) : 1;

    logic [ROW_W-1:0]   row_cnt;
    logic [ROW_W-1:0]   row_sel;
    logic               last_row;
    logic               wr_fire;
    act_t [NUM_COL-1:0] rq_row;

    // Negative sums clamp to zero, zero point wraps in 8 bits
    function automatic act_t requant(psum_t sum, shift_t sh, act_t zp);
        psum_t shifted;
        if (sum < 0) begin
            return '0;
        end
        shifted = sum >>> sh;
        return act_t'(shifted) + zp;
    endfunction

    assign last_row   = (row_cnt == ROW_W'(NUM_ROW - 1));
    assign wr_fire    = ofm_wr_vld & ofm_wr_rdy;
    assign write_done = wr_fire & last_row;

    // Row 0 on drain done, else the row after the current one
    assign row_sel = drain_done ? '0 : row_cnt + 1'b1;

    always_comb begin
        for (int c = 0; c < NUM_COL; c++) begin
            rq_row[c] = requant(psum[row_sel][c], cfg_q.shift, cfg_q.zp);
        end
    end

    // ==============================
    // Row sequencing
    // ==============================
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            ofm_wr_vld <= 1'b0;
            row_cnt    <= '0;
        end else if (drain_done) begin
            ofm_wr_vld <= 1'b1;
            row_cnt    <= '0;
        end else if (wr_fire) begin
            if (last_row) begin
                ofm_wr_vld <= 1'b0;
            end else begin
                row_cnt <= row_cnt + 1'b1;
            end
        end
    end

    // Row data and address hold until the handshake
    always_ff @(posedge clk) begin
        if (drain_done) begin
            ofm_wr_dat  <= rq_row;
            ofm_wr_addr <= cfg_q.ofm_base;
        end else if (wr_fire && !last_row) begin
            ofm_wr_dat  <= rq_row;
            ofm_wr_addr <= ofm_wr_addr + 1'b1;
        end
    end

endmodule

`default_nettype wire

// ==== sya_top.sv ====
// Systolic matrix engine top level
// Sequencer, PE grid and output writer

`timescale 1ns/100ps
`default_nettype none

module sya_top #(
    parameter int NUM_ROW = 4,
    parameter int NUM_COL = 4
) (
    input  wire                             clk,
    input  wire                             rst_n,
    // Configuration
    input  wire                             cfg_vld,
    input  sya_pkg::sya_cfg_t               cfg,
    output logic                            cfg_rdy,
    // Activation read
    output sya_pkg::addr_t                  act_rd_addr,
    output logic                            act_rd_addr_vld,
    input  wire                             act_rd_addr_rdy,
    input  sya_pkg::act_t [NUM_ROW-1:0]     act_rd_dat,
    input  wire                             act_rd_dat_vld,
    output logic                            act_rd_dat_rdy,
    // Weight read
    output sya_pkg::addr_t                  wgt_rd_addr,
    output logic                            wgt_rd_addr_vld,
    input  wire                             wgt_rd_addr_rdy,
    input  sya_pkg::wgt_t [NUM_COL-1:0]     wgt_rd_dat,
    input  wire                             wgt_rd_dat_vld,
    output logic                            wgt_rd_dat_rdy,
    // Output write
    output logic                            ofm_wr_vld,
    output sya_pkg::addr_t                  ofm_wr_addr,
    output sya_pkg::act_t [NUM_COL-1:0]     ofm_wr_dat,
    input  wire                             ofm_wr_rdy
);
    import sya_pkg::*;

    wire sya_cfg_t                          cfg_q;
    wire                                    step;
    wire                                    feed_zero;
    wire                                    clear_acc;
    wire                                    drain_done;
    wire                                    write_done;
    wire psum_t [NUM_ROW-1:0][NUM_COL-1:0]  psum;

    sya_seq #(
        .NUM_ROW (NUM_ROW),
        .NUM_COL (NUM_COL)
    ) u_seq (
        .clk             (clk),
        .rst_n           (rst_n),
        .cfg_vld         (cfg_vld),
        .cfg             (cfg),
        .act_rd_addr_rdy (act_rd_addr_rdy),
        .wgt_rd_addr_rdy (wgt_rd_addr_rdy),
        .act_rd_dat_vld  (act_rd_dat_vld),
        .wgt_rd_dat_vld  (wgt_rd_dat_vld),
        .write_done      (write_done),
        .cfg_rdy         (cfg_rdy),
        .cfg_q           (cfg_q),
        .act_rd_addr     (act_rd_addr),
        .wgt_rd_addr     (wgt_rd_addr),
        .act_rd_addr_vld (act_rd_addr_vld),
        .wgt_rd_addr_vld (wgt_rd_addr_vld),
        .act_rd_dat_rdy  (act_rd_dat_rdy),
        .wgt_rd_dat_rdy  (wgt_rd_dat_rdy),
        .step            (step),
        .feed_zero       (feed_zero),
        .clear_acc       (clear_acc),
        .drain_done      (drain_done)
    );

    sya_array #(
        .NUM_ROW (NUM_ROW),
        .NUM_COL (NUM_COL)
    ) u_array (
        .clk       (clk),
        .rst_n     (rst_n),
        .step      (step),
        .feed_zero (feed_zero),
        .clear_acc (clear_acc),
        .act_vec   (act_rd_dat),
        .wgt_vec   (wgt_rd_dat),
        .psum      (psum)
    );

    sya_ofm_writer #(
        .NUM_ROW (NUM_ROW),
        .NUM_COL (NUM_COL)
    ) u_writer (
        .clk         (clk),
        .rst_n       (rst_n),
        .drain_done  (drain_done),
        .cfg_q       (cfg_q),
        .psum        (psum),
        .ofm_wr_rdy  (ofm_wr_rdy),
        .ofm_wr_vld  (ofm_wr_vld),
        .ofm_wr_addr (ofm_wr_addr),
        .ofm_wr_dat  (ofm_wr_dat),
        .write_done  (write_done)
    );

endmodule

`default_nettype wire

// ==== sya_asserts.sv ====
// Handshake assertions for the systolic matrix engine
// Bound into the top level

`timescale 1ns/100ps
`default_nettype none

module sya_handshake_asserts #(
    parameter int NUM_COL = 4
) (
    input wire                          clk,
    input wire                          rst_n,
    input wire                          cfg_rdy,
    input sya_pkg::seq_state_t          state,
    input wire                          act_rd_addr_vld,
    input wire                          wgt_rd_addr_vld,
    input wire                          act_rd_addr_rdy,
    input wire                          wgt_rd_addr_rdy,
    input wire                          ofm_wr_vld,
    input wire                          ofm_wr_rdy,
    input sya_pkg::addr_t               ofm_wr_addr,
    input sya_pkg::act_t [NUM_COL-1:0]  ofm_wr_dat
);
    import sya_pkg::*;

    // Stalled row keeps data, address and valid
    a_ofm_hold: assert property (@(posedge clk) disable iff (!rst_n)
        ofm_wr_vld && !ofm_wr_rdy |=> ofm_wr_vld && $stable(ofm_wr_dat) && $stable(ofm_wr_addr))
        else $error("ofm write changed while stalled");

    a_cfg_rdy: assert property (@(posedge clk) disable iff (!rst_n)
        (state != IDLE) |-> !cfg_rdy)
        else $error("cfg_rdy high outside IDLE");

    // Cross-ready request rule
    a_act_cross: assert property (@(posedge clk) disable iff (!rst_n)
        act_rd_addr_vld |-> wgt_rd_addr_rdy)
        else $error("act_rd_addr_vld without wgt_rd_addr_rdy");

    a_wgt_cross: assert property (@(posedge clk) disable iff (!rst_n)
        wgt_rd_addr_vld |-> act_rd_addr_rdy)
        else $error("wgt_rd_addr_vld without act_rd_addr_rdy");

endmodule

bind sya_top sya_handshake_asserts #(
    .NUM_COL (NUM_COL)
) u_asserts (
    .clk             (clk),
    .rst_n           (rst_n),
    .cfg_rdy         (cfg_rdy),
    .state           (u_seq.state),
    .act_rd_addr_vld (act_rd_addr_vld),
    .wgt_rd_addr_vld (wgt_rd_addr_vld),
    .act_rd_addr_rdy (act_rd_addr_rdy),
    .wgt_rd_addr_rdy (wgt_rd_addr_rdy),
    .ofm_wr_vld      (ofm_wr_vld),
    .ofm_wr_rdy      (ofm_wr_rdy),
    .ofm_wr_addr     (ofm_wr_addr),
    .ofm_wr_dat      (ofm_wr_dat)
);

`default_nettype wire

// ==== tb_sya.sv ====
// Testbench for the systolic matrix engine
// Buffer model, random stalls and a reference model of the requantized rows

`timescale 1ns/100ps
`default_nettype none

module tb_sya;
    import sya_pkg::*;

    localparam int NUM_ROW   = 4;
    localparam int NUM_COL   = 4;
    localparam int NUM_JOBS  = 8;
    localparam int WAIT_MAX  = 4000;

    typedef act_t [NUM_COL-1:0] row_t;

    logic                 clk = 1'b0;
    logic                 rst_n;
    logic                 cfg_vld;
    sya_cfg_t             cfg;
    logic                 cfg_rdy;
    addr_t                act_rd_addr;
    addr_t                wgt_rd_addr;
    logic                 act_rd_addr_vld;
    logic                 wgt_rd_addr_vld;
    logic                 act_rd_addr_rdy = 1'b0;
    logic                 wgt_rd_addr_rdy = 1'b0;
    act_t [NUM_ROW-1:0]   act_rd_dat = '0;
    wgt_t [NUM_COL-1:0]   wgt_rd_dat = '0;
    logic                 act_rd_dat_vld = 1'b0;
    logic                 wgt_rd_dat_vld = 1'b0;
    logic                 act_rd_dat_rdy;
    logic                 wgt_rd_dat_rdy;
    logic                 ofm_wr_vld;
    addr_t                ofm_wr_addr;
    row_t                 ofm_wr_dat;
    logic                 ofm_wr_rdy = 1'b0;

    // Buffer contents and job list
    act_t [NUM_ROW-1:0]   act_mem [256];
    wgt_t [NUM_COL-1:0]   wgt_mem [256];
    sya_cfg_t             jobs [NUM_JOBS];

    // Monitor state
    logic [31:0]          lfsr = 32'd90163;
    sya_cfg_t             cur_cfg = '0;
    addr_t                act_q [$];
    addr_t                wgt_q [$];
    int                   due_q [$];
    chn_t                 req_seen = '0;
    chn_t                 beat_seen = '0;
    logic                 req_open = 1'b0;
    logic                 beat_open = 1'b0;
    int                   rows_seen = 0;
    int                   cycle_cnt = 0;
    int                   accepted = 0;
    int                   jobs_done = 0;
    logic                 busy = 1'b0;
    logic                 drv_live = 1'b0;
    int                   checks = 0;
    int                   errors = 0;
    int                   timeouts = 0;

    sya_top #(
        .NUM_ROW (NUM_ROW),
        .NUM_COL (NUM_COL)
    ) u_dut (
        .clk             (clk),
        .rst_n           (rst_n),
        .cfg_vld         (cfg_vld),
        .cfg             (cfg),
        .cfg_rdy         (cfg_rdy),
        .act_rd_addr     (act_rd_addr),
        .act_rd_addr_vld (act_rd_addr_vld),
        .act_rd_addr_rdy (act_rd_addr_rdy),
        .act_rd_dat      (act_rd_dat),
        .act_rd_dat_vld  (act_rd_dat_vld),
        .act_rd_dat_rdy  (act_rd_dat_rdy),
        .wgt_rd_addr     (wgt_rd_addr),
        .wgt_rd_addr_vld (wgt_rd_addr_vld),
        .wgt_rd_addr_rdy (wgt_rd_addr_rdy),
        .wgt_rd_dat      (wgt_rd_dat),
        .wgt_rd_dat_vld  (wgt_rd_dat_vld),
        .wgt_rd_dat_rdy  (wgt_rd_dat_rdy),
        .ofm_wr_vld      (ofm_wr_vld),
        .ofm_wr_addr     (ofm_wr_addr),
        .ofm_wr_dat      (ofm_wr_dat),
        .ofm_wr_rdy      (ofm_wr_rdy)
    );

    always #50 clk = ~clk;

    // ==============================
    // Random numbers
    // ==============================
    function automatic logic [31:0] next_lfsr(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h80200003) : (s >> 1);
    endfunction

    // One LFSR step per bit taken
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = next_lfsr(lfsr);
            v = {v[30:0], lfsr[0]};
        end
        return v;
    endfunction

    // Expected row: dot products over channels, then ReLU, shift, zero point
    function automatic row_t ref_row(input sya_cfg_t c, input int r);
        row_t   res;
        longint sum;
        addr_t  a_addr;
        addr_t  w_addr;
        for (int col = 0; col < NUM_COL; col++) begin
            sum = 0;
            for (int k = 0; k < int'(c.num_chn); k++) begin
                a_addr = c.act_base + addr_t'(k);
                w_addr = c.wgt_base + addr_t'(k);
                sum += longint'(act_mem[a_addr[7:0]][r]) * longint'(wgt_mem[w_addr[7:0]][col]);
            end
            if (sum < 0) begin
                res[col] = '0;
            end else begin
                res[col] = act_t'(sum >>> c.shift) + c.zp;
            end
        end
        return res;
    endfunction

    // ==============================
    // Compare tasks
    // ==============================
    task automatic check_bit(input string name, input logic got, input logic exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("Fail %0d ns: %s got %b expected %b", $time, name, got, exp);
        end
    endtask

    task automatic check_addr(input string name, input addr_t got, input addr_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("Fail %0d ns: %s got 0x%04h expected 0x%04h", $time, name, got, exp);
        end
    endtask

    task automatic check_count(input string name, input chn_t got, input chn_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("Fail %0d ns: %s got %0d expected %0d", $time, name, got, exp);
        end
    endtask

    task automatic check_row(input int row, input row_t got, input row_t exp);
        for (int c = 0; c < NUM_COL; c++) begin
            checks++;
            if (got[c] !== exp[c]) begin
                errors++;
                $display("Fail %0d ns: ofm_wr_dat row %0d col %0d got %0d expected %0d",
                         $time, row, c, got[c], exp[c]);
            end
        end
    endtask

    task automatic finish_run();
        $display("Checks %0d, errors %0d, timeouts %0d", checks, errors, timeouts);
        if (errors == 0 && timeouts == 0) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    endtask

    task automatic wait_accepted(input int n);
        int t;
        t = 0;
        while (accepted < n && t < WAIT_MAX) begin
            @(posedge clk);
            #1;
            t++;
        end
        if (accepted < n) begin
            timeouts++;
            $display("Timeout: configuration %0d was never accepted", n - 1);
        end
    endtask

    task automatic wait_done(input int n);
        int t;
        t = 0;
        while (jobs_done < n && t < WAIT_MAX) begin
            @(posedge clk);
            #1;
            t++;
        end
        if (jobs_done < n) begin
            timeouts++;
            $display("Timeout: job %0d did not write all its rows", n - 1);
        end
    endtask

    // ==============================
    // Monitor, sampled on the rising edge
    // ==============================
    always @(posedge clk) begin
        if (rst_n) begin
            cycle_cnt++;
            check_bit("cfg_rdy", cfg_rdy, !busy);
            // Request and data enables while the job still needs them
            req_open  = busy && (req_seen != cur_cfg.num_chn);
            beat_open = busy && (beat_seen != cur_cfg.num_chn);
            check_bit("act_rd_addr_vld", act_rd_addr_vld, req_open && wgt_rd_addr_rdy);
            check_bit("wgt_rd_addr_vld", wgt_rd_addr_vld, req_open && act_rd_addr_rdy);
            check_bit("act_rd_dat_rdy", act_rd_dat_rdy, beat_open);
            check_bit("wgt_rd_dat_rdy", wgt_rd_dat_rdy, beat_open);
            if (cfg_vld && cfg_rdy) begin
                cur_cfg   = cfg;
                req_seen  = '0;
                beat_seen = '0;
                rows_seen = 0;
                busy      = 1'b1;
                accepted++;
            end
            // Requests go to the buffer queue with a random answer delay
            if (act_rd_addr_vld && act_rd_addr_rdy) begin
                check_addr("act_rd_addr", act_rd_addr, cur_cfg.act_base + req_seen);
                check_addr("wgt_rd_addr", wgt_rd_addr, cur_cfg.wgt_base + req_seen);
                act_q.push_back(act_rd_addr);
                wgt_q.push_back(wgt_rd_addr);
                due_q.push_back(cycle_cnt + int'(rand_bits(2)));
                req_seen++;
            end
            if (act_rd_dat_vld && act_rd_dat_rdy && wgt_rd_dat_vld && wgt_rd_dat_rdy) begin
                if (act_q.size() == 0) begin
                    errors++;
                    $display("Read data taken with no request outstanding at %0d ns", $time);
                end else begin
                    act_q.delete(0);
                    wgt_q.delete(0);
                    due_q.delete(0);
                end
                beat_seen++;
            end
            if (ofm_wr_vld && ofm_wr_rdy) begin
                check_addr("ofm_wr_addr", ofm_wr_addr, cur_cfg.ofm_base + addr_t'(rows_seen));
                check_row(rows_seen, ofm_wr_dat, ref_row(cur_cfg, rows_seen));
                rows_seen++;
                if (rows_seen == NUM_ROW) begin
                    check_count("read requests", req_seen, cur_cfg.num_chn);
                    check_count("read beats", beat_seen, cur_cfg.num_chn);
                    busy = 1'b0;
                    jobs_done++;
                end
            end
        end
    end

    // Buffer and sink driver, 1 ns after the edge
    always @(posedge clk) begin
        drv_live = rst_n;
        #1;
        if (drv_live) begin
            act_rd_addr_rdy = (rand_bits(2) != 0);
            wgt_rd_addr_rdy = (rand_bits(2) != 0);
            ofm_wr_rdy      = (rand_bits(1) != 0);
            if (act_q.size() > 0 && cycle_cnt >= due_q[0]) begin
                act_rd_dat_vld = 1'b1;
                wgt_rd_dat_vld = 1'b1;
                act_rd_dat     = act_mem[act_q[0][7:0]];
                wgt_rd_dat     = wgt_mem[wgt_q[0][7:0]];
            end else begin
                act_rd_dat_vld = 1'b0;
                wgt_rd_dat_vld = 1'b0;
            end
        end
    end

    // ==============================
    // Main sequence
    // ==============================
    initial begin
        rst_n   = 1'b0;
        cfg_vld = 1'b0;
        cfg     = '0;
        for (int a = 0; a < 256; a++) begin
            for (int r = 0; r < NUM_ROW; r++) begin
                act_mem[a][r] = act_t'(rand_bits(8));
            end
            for (int c = 0; c < NUM_COL; c++) begin
                wgt_mem[a][c] = wgt_t'(rand_bits(8));
            end
        end
        // First job is a single channel with plain ReLU
        for (int j = 0; j < NUM_JOBS; j++) begin
            jobs[j].ofm_base = addr_t'(rand_bits(16));
            jobs[j].act_base = addr_t'(rand_bits(16));
            jobs[j].wgt_base = addr_t'(rand_bits(16));
            jobs[j].num_chn  = (j == 0) ? chn_t'(1) : chn_t'(1 + int'(rand_bits(5)) % 20);
            jobs[j].shift    = (j == 0) ? shift_t'(0) : shift_t'(rand_bits(4));
            jobs[j].zp       = (j == 0) ? act_t'(0) : act_t'(rand_bits(8));
        end

        repeat (4) @(posedge clk);
        #1;
        rst_n = 1'b1;
        check_bit("cfg_rdy", cfg_rdy, 1'b1);
        check_bit("act_rd_addr_vld", act_rd_addr_vld, 1'b0);
        check_bit("wgt_rd_addr_vld", wgt_rd_addr_vld, 1'b0);
        check_bit("act_rd_dat_rdy", act_rd_dat_rdy, 1'b0);
        check_bit("wgt_rd_dat_rdy", wgt_rd_dat_rdy, 1'b0);
        check_bit("ofm_wr_vld", ofm_wr_vld, 1'b0);

        // Even jobs are followed at once by the next one
        for (int j = 0; j < NUM_JOBS && timeouts == 0; j++) begin
            cfg     = jobs[j];
            cfg_vld = 1'b1;
            wait_accepted(j + 1);
            cfg_vld = 1'b0;
            if (j % 2 == 1 && timeouts == 0) begin
                wait_done(j + 1);
                repeat (3) @(posedge clk);
                #1;
            end
        end
        if (timeouts == 0) begin
            wait_done(NUM_JOBS);
        end
        check_bit("cfg_rdy", cfg_rdy, 1'b1);
        finish_run();
    end

endmodule

`default_nettype wire

// ==== all.f ====
sya_pkg.sv
sya_pe.sv
sya_array.sv
sya_seq.sv
sya_ofm_writer.sv
sya_top.sv
sya_asserts.sv
tb_sya.sv

// ==== run.sh ====
#!/usr/bin/env bash
# Compile and run the systolic engine testbench with Verilator
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -Wno-fatal --top-module tb_sya -f all.f -o sim_sya \
    && ./obj_dir/sim_sya | tee /dev/stderr | grep -qF "Simulation PASSED" \
    && echo "Run passed" \
    || { echo "Run failed"; exit 1; }
